/* logic/subbank_mem_pkg.sv */
// sizes and vector types shared by the lane-split memory.
// a full word is cut into NUM_LANES lanes of LANE_W bits each, and every
// lane lives in its own bank of DEPTH entries.
package subbank_mem_pkg;

  // number of lanes that one word is split into.
  localparam int NUM_LANES = 4;

  // bits held by a single lane.
  localparam int LANE_W = 8;

  // full word width, always lanes times lane width.
  localparam int WORD_W = NUM_LANES * LANE_W;

  // words stored in each lane bank.
  localparam int DEPTH = 16;

  // word address width, sized to cover DEPTH.
  localparam int ADDR_W = $clog2(DEPTH);

  // one full word.
  // the same type carries the per-bit write mask.
  typedef logic [WORD_W-1:0] word_t;

  // one lane of data, or one lane of the write mask.
  typedef logic [LANE_W-1:0] lane_t;

  // word address, shared by all lanes of a request.
  typedef logic [ADDR_W-1:0] addr_t;

  // one flag per lane.
  // used for request valids, write enables and read flags.
  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

/* logic/subbank_req_split.sv */
`timescale 1ns/1ps

// request front end.
// the incoming request is registered once and then presented to the lane
// banks as per-lane enables, write enables, data slices and mask slices.
// everything comes out one cycle after the request was taken.
module subbank_req_split import subbank_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  lane_mask_t v_i,
  input  logic       w_i,
  input  addr_t      addr_i,
  input  word_t      data_i,
  input  word_t      w_mask_i,
  output lane_mask_t lane_en_o,
  output lane_mask_t lane_we_o,
  output addr_t      lane_addr_o,
  output lane_t      lane_data_o  [NUM_LANES],
  output lane_t      lane_bmask_o [NUM_LANES],
  output lane_mask_t lane_rd_o
);

  // registered copy of the request.
  lane_mask_t v_q;
  logic       w_q;
  addr_t      addr_q;
  word_t      data_q;
  word_t      mask_q;

  // a request is present whenever any lane valid is set.
  logic req_take;

  assign req_take = |v_i;

  // the lane valids are control state and clear on reset.
  // they follow v_i every cycle, so an idle cycle drops all enables.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      v_q <= '0;
    end else begin
      v_q <= v_i;
    end
  end

  // the payload is only loaded when a request is taken.
  // while idle it keeps the previous request, which no bank looks at.
  always_ff @(posedge clk) begin
    if (req_take) begin
      w_q    <= w_i;
      addr_q <= addr_i;
      data_q <= data_i;
      mask_q <= w_mask_i;
    end
  end

  // lanes that are valid take part in the access.
  assign lane_en_o = v_q;

  // a write request writes every valid lane.
  assign lane_we_o = v_q & {NUM_LANES{w_q}};

  // a read request reads every valid lane.
  // the collector uses this to know which lanes to refresh.
  assign lane_rd_o = v_q & ~{NUM_LANES{w_q}};

  // all lanes share the same word address.
  assign lane_addr_o = addr_q;

  // lane k takes bits k*LANE_W up to k*LANE_W+LANE_W-1 of data and mask.
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_slice
    assign lane_data_o[k]  = data_q[k*LANE_W +: LANE_W];
    assign lane_bmask_o[k] = mask_q[k*LANE_W +: LANE_W];
  end

endmodule

/* logic/subbank_bank.sv */
`timescale 1ns/1ps

// storage for one lane.
// a single-port RAM of DEPTH words, LANE_W bits wide, with a per-bit
// write mask and a registered read port.
// an access is taken at the clock edge that ends the cycle in which en_i
// is set; a read shows up on q_o right after that edge.
module subbank_bank import subbank_mem_pkg::*; (
  input  logic  clk,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  lane_t data_i,
  input  lane_t bmask_i,
  output lane_t q_o
);

  // the array itself.
  lane_t mem [DEPTH];

  // decoded access type.
  logic wr_en;
  logic rd_en;

  // current content of the addressed word.
  lane_t cur_word;

  // word to store back on a write, built from old and new bits.
  lane_t wr_word;

  // registered read data.
  lane_t q_q;

  // the port does either a write or a read in one cycle, never both.
  assign wr_en = en_i & we_i;
  assign rd_en = en_i & ~we_i;

  assign cur_word = mem[addr_i];

  // bits with the mask set come from data_i.
  // all other bits keep what the array held before.
  assign wr_word = (cur_word & ~bmask_i) | (data_i & bmask_i);

  // write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr_i] <= wr_word;
    end
  end

  // read port.
  // q_q only changes on a read, so it still shows the last word read
  // while the lane is idle or being written.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      q_q <= cur_word;
    end
  end

  assign q_o = q_q;

endmodule

/* logic/subbank_read_collect.sv */
`timescale 1ns/1ps

// read collector.
// lane read flags arrive from the splitter one cycle ahead of the bank
// data, so they are delayed here by one cycle first. every flagged lane
// then captures its bank output into a hold register. lanes that were not
// read keep the last value read on them.
module subbank_read_collect import subbank_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  lane_mask_t lane_rd_i,
  input  lane_t      lane_q_i [NUM_LANES],
  output word_t      data_o,
  output lane_mask_t rd_v_o
);

  // read flags lined up with the bank output.
  lane_mask_t rd_d;

  // lanes refreshed at the last edge.
  lane_mask_t rd_v_q;

  // last value read on each lane.
  lane_t hold_q [NUM_LANES];

  // the delay stage lines the flags up with the cycle in which the
  // banks present the read word.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_d <= '0;
    end else begin
      rd_d <= lane_rd_i;
    end
  end

  // the refresh mask goes out together with the captured data.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_v_q <= '0;
    end else begin
      rd_v_q <= rd_d;
    end
  end

  // one hold register per lane.
  // only lanes flagged as read take the new bank word.
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_hold
    always_ff @(posedge clk) begin
      if (rst_i) begin
        hold_q[k] <= '0;
      end else if (rd_d[k]) begin
        hold_q[k] <= lane_q_i[k];
      end
    end

    // lane k of the word goes back to bits k*LANE_W and up.
    assign data_o[k*LANE_W +: LANE_W] = hold_q[k];
  end

  assign rd_v_o = rd_v_q;

endmodule

/* logic/subbank_mem_top.sv */
`timescale 1ns/1ps

// lane-split single-port memory.
// a request passes the splitter, one bank per lane and the collector, so
// a read shows on data_o three cycles after it was presented. a new
// request can be presented every cycle.
module subbank_mem_top import subbank_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  lane_mask_t v_i,
  input  logic       w_i,
  input  addr_t      addr_i,
  input  word_t      data_i,
  input  word_t      w_mask_i,
  output word_t      data_o,
  output lane_mask_t rd_v_o
);

  // splitter to banks.
  lane_mask_t lane_en;
  lane_mask_t lane_we;
  addr_t      lane_addr;
  lane_t      lane_data [NUM_LANES];
  lane_t      lane_mask [NUM_LANES];

  // splitter to collector.
  lane_mask_t lane_rd;

  // banks to collector.
  lane_t lane_q [NUM_LANES];

  subbank_req_split u_split (
    .clk          (clk),
    .rst_i        (rst_i),
    .v_i          (v_i),
    .w_i          (w_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .w_mask_i     (w_mask_i),
    .lane_en_o    (lane_en),
    .lane_we_o    (lane_we),
    .lane_addr_o  (lane_addr),
    .lane_data_o  (lane_data),
    .lane_bmask_o (lane_mask),
    .lane_rd_o    (lane_rd)
  );

  // one bank per lane, all sharing the word address.
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    subbank_bank u_bank (
      .clk     (clk),
      .en_i    (lane_en[k]),
      .we_i    (lane_we[k]),
      .addr_i  (lane_addr),
      .data_i  (lane_data[k]),
      .bmask_i (lane_mask[k]),
      .q_o     (lane_q[k])
    );
  end

  subbank_read_collect u_collect (
    .clk       (clk),
    .rst_i     (rst_i),
    .lane_rd_i (lane_rd),
    .lane_q_i  (lane_q),
    .data_o    (data_o),
    .rd_v_o    (rd_v_o)
  );

endmodule

/* tests/subbank_mem_model.svh */
`ifndef SUBBANK_MEM_MODEL_SVH
`define SUBBANK_MEM_MODEL_SVH

// reference model of the lane-split memory.
// shadow_mem mirrors the lane arrays and model_hold mirrors the last value
// read on every lane. requests are applied in issue order, which matches
// the hardware because a write reaches the array before any later read.

lane_t shadow_mem [NUM_LANES][DEPTH];
lane_t model_hold [NUM_LANES];

// one step of a 32-bit xorshift generator.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// the collector holds zero on every lane after reset.
function automatic void model_clear();
  for (int k = 0; k < NUM_LANES; k++) begin
    model_hold[k] = '0;
  end
endfunction

// applies one request to the model and returns the response that the
// memory must show three cycles later.
// a write only changes the masked bits of the valid lanes and refreshes
// no lane. a read refreshes exactly the valid lanes.
function automatic void ref_step(input lane_mask_t v, input logic w, input addr_t a,
                                 input word_t d, input word_t m,
                                 output word_t exp_d, output lane_mask_t exp_v);
  lane_t dl;
  lane_t ml;
  for (int k = 0; k < NUM_LANES; k++) begin
    dl = d[k*LANE_W +: LANE_W];
    ml = m[k*LANE_W +: LANE_W];
    if (v[k] && w) begin
      // every bit with its mask bit set takes the new data bit.
      for (int b = 0; b < LANE_W; b++) begin
        if (ml[b]) begin
          shadow_mem[k][a][b] = dl[b];
        end
      end
    end else if (v[k]) begin
      model_hold[k] = shadow_mem[k][a];
    end
  end
  exp_v = w ? '0 : v;
  for (int k = 0; k < NUM_LANES; k++) begin
    exp_d[k*LANE_W +: LANE_W] = model_hold[k];
  end
endfunction

`endif

/* tests/subbank_mem_tb.sv */
`timescale 1ns/1ps

module subbank_mem_tb import subbank_mem_pkg::*; ();

  // request counts of the test phases.
  localparam int FILL_CYCLES   = DEPTH;
  localparam int FULL_RD_CYCLES = DEPTH;
  localparam int MASK_CYCLES   = 8;
  localparam int PART_CYCLES   = 8;
  localparam int RAND_CYCLES   = 400;
  localparam int DRAIN_CYCLES  = 3;
  localparam int ISSUE_CYCLES  = FILL_CYCLES + FULL_RD_CYCLES + MASK_CYCLES +
                                 PART_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * ISSUE_CYCLES + 50;

  logic       clk = 1'b0;
  logic       rst_i;
  lane_mask_t v_i;
  logic       w_i;
  addr_t      addr_i;
  word_t      data_i;
  word_t      w_mask_i;
  word_t      data_o;
  lane_mask_t rd_v_o;

  `include "subbank_mem_model.svh"

  // expected responses, oldest first.
  // the head always belongs to the request issued three cycles earlier.
  word_t      exp_data_q [$];
  lane_mask_t exp_rdv_q  [$];

  logic [31:0] rng_state = 32'he03fb91a;
  logic        armed     = 1'b0;
  int          cycle_cnt = 0;

  // lane patterns for the partial reads.
  lane_mask_t part_v [PART_CYCLES] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                       4'b0101, 4'b1010, 4'b0011, 4'b1100};

  subbank_mem_top dut0 (
    .clk      (clk),
    .rst_i    (rst_i),
    .v_i      (v_i),
    .w_i      (w_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .w_mask_i (w_mask_i),
    .data_o   (data_o),
    .rd_v_o   (rd_v_o)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // drives one request on the falling edge and queues its response.
  task automatic issue_req(input lane_mask_t v, input logic w, input addr_t a,
                           input word_t d, input word_t m);
    word_t      exp_d;
    lane_mask_t exp_v;
    @(negedge clk);
    v_i      = v;
    w_i      = w;
    addr_i   = a;
    data_i   = d;
    w_mask_i = m;
    ref_step(v, w, a, d, m, exp_d, exp_v);
    exp_data_q.push_back(exp_d);
    exp_rdv_q.push_back(exp_v);
  endtask

  // outputs change on the rising edge, so they are sampled on the falling edge.
  initial begin
    word_t      exp_d;
    lane_mask_t exp_v;
    wait (armed);
    forever begin
      @(negedge clk);
      if (exp_data_q.size() == 0) begin
        $display("the expected response queue ran empty during checking");
        $display("Checks failed");
        $fatal(1, "response queue underflow");
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_v = exp_rdv_q.pop_front();
        check_value("data_o", data_o, exp_d);
        check_value("rd_v_o", {28'd0, rd_v_o}, {28'd0, exp_v});
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] r;
    lane_mask_t  rv;
    logic        rw;
    addr_t       ra;
    addr_t       last_addr;
    logic        last_w;
    rst_i    = 1'b1;
    v_i      = '0;
    w_i      = 1'b0;
    addr_i   = '0;
    data_i   = '0;
    w_mask_i = '0;
    model_clear();
    repeat (8) @(negedge clk);
    rst_i = 1'b0;

    // nothing has been read yet.
    check_value("rd_v_o", {28'd0, rd_v_o}, 32'd0);
    check_value("data_o", data_o, 32'd0);

    // the first three checked cycles still show the reset state.
    repeat (3) begin
      exp_data_q.push_back('0);
      exp_rdv_q.push_back('0);
    end
    armed = 1'b1;

    // full writes with every bit enabled, then full reads.
    for (int a = 0; a < DEPTH; a++) begin
      issue_req(4'hf, 1'b1, addr_t'(a), next_rand(), '1);
    end
    for (int a = 0; a < DEPTH; a++) begin
      issue_req(4'hf, 1'b0, addr_t'(a), '0, '0);
    end

    // masked writes, each read back in the very next cycle.
    for (int i = 0; i < MASK_CYCLES / 2; i++) begin
      ra = addr_t'(3 * i + 2);
      issue_req(4'hf, 1'b1, ra, next_rand(), next_rand());
      issue_req(4'hf, 1'b0, ra, '0, '0);
    end

    // reads on some lanes only, so the others must keep their last value.
    for (int i = 0; i < PART_CYCLES; i++) begin
      issue_req(part_v[i], 1'b0, addr_t'(2 * i + 1), '0, '0);
    end

    // random back-to-back traffic.
    // now and then a read is steered onto the address just written.
    last_w    = 1'b0;
    last_addr = '0;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      r  = next_rand();
      rv = r[3:0];
      rw = r[4];
      ra = r[11:8];
      if (last_w && r[7:5] == 3'd0) begin
        rw = 1'b0;
        ra = last_addr;
        if (rv == '0) begin
          rv = 4'hf;
        end
      end
      issue_req(rv, rw, ra, next_rand(), next_rand());
      last_w    = rw && (rv != '0);
      last_addr = ra;
    end

    // idle cycles let the last reads come out.
    repeat (DRAIN_CYCLES) begin
      issue_req('0, 1'b0, '0, '0, '0);
    end
    @(posedge clk);

    $display("All checks passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+tests
logic/subbank_mem_pkg.sv
logic/subbank_req_split.sv
logic/subbank_bank.sv
logic/subbank_read_collect.sv
logic/subbank_mem_top.sv
tests/subbank_mem_tb.sv

/* Makefile */
# Verilator build and run of the lane-split memory testbench.
# any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= subbank_mem_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

BIN := $(BUILD_DIR)/V$(TOP)

SRCS := $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# the binary is rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the exit status of the simulator is the result of the run.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
